/* hdl/hit_capture_pkg.sv */
`default_nettype none

package hit_capture_pkg;

	// number of hit inputs on the front end
	localparam int num_channels_default = 4;

	// free-running stamp, wraps after 2**16 cycles
	localparam int timestamp_width_default = 16;

	// kept small so counters can saturate in a short run
	localparam int count_width_default = 8;

	// width of a channel index, never below one bit
	function automatic int channel_index_width(input int channels);
		int width;
		width = 1;
		if (channels > 2) begin
			width = $clog2(channels);
		end
		return width;
	endfunction

	// one entry per clock cycle that saw any hits
	typedef struct packed {
		logic [timestamp_width_default-1:0] timestamp;
		logic [num_channels_default-1:0] hit_mask;
	} hit_record_t;

endpackage

`default_nettype wire

/* hdl/pulse_catcher.sv */
`default_nettype none

module pulse_catcher (
	input wire logic clock,
	input wire logic randy,
	input wire logic hit_in,
	output logic sync_level
);

	// first stage, clocked by the hit itself
	logic stage_one;

	// clock domain stages
	logic stage_two;
	logic stage_three;

	// clears the asynchronous front stages
	logic catch_clear;

	// release the catch once the pulse has gone and the
	// clock domain has seen it in stage three; a long pulse
	// keeps the catch set until the input drops
	assign catch_clear = randy | (~hit_in & stage_three);

	// a pulse shorter than a clock period still sets this
	always_ff @(posedge hit_in or posedge catch_clear) begin
		if (catch_clear) begin
			stage_one <= 1'b0;
		end else begin
			stage_one <= 1'b1;
		end
	end

	// first clocked stage, may go metastable
	// cleared together with stage one so the next pulse starts clean
	always_ff @(posedge clock or posedge catch_clear) begin
		if (catch_clear) begin
			stage_two <= 1'b0;
		end else begin
			stage_two <= stage_one;
		end
	end

	// settling stage and output register
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			stage_three <= 1'b0;
		end else begin
			stage_three <= stage_two;
		end
	end

	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			sync_level <= 1'b0;
		end else begin
			sync_level <= stage_three;
		end
	end

endmodule

`default_nettype wire

/* hdl/edge_to_pulse.sv */
`default_nettype none

module edge_to_pulse #(
	parameter int depth = 3
) (
	input wire logic clock,
	input wire logic randy,
	input wire logic level,
	output logic pulse
);

	// past samples of the level, stream[0] is the most recent
	logic [depth-1:0] stream;

	// newest sample high, the one before it low
	logic rise;

	// level was low over the older part of the history
	logic quiet;

	assign rise = level & ~stream[0];
	assign quiet = ~|stream[depth-1:1];

	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			stream <= '0;
		end else begin
			stream <= {stream[depth-2:0], level};
		end
	end

	// one cycle wide, a bouncing level does not retrigger
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			pulse <= 1'b0;
		end else begin
			pulse <= rise & quiet;
		end
	end

endmodule

`default_nettype wire

/* hdl/hit_recorder.sv */
`default_nettype none

module hit_recorder
	import hit_capture_pkg::*;
#(
	parameter int num_channels = num_channels_default,
	parameter int timestamp_width = timestamp_width_default
) (
	input wire logic clock,
	input wire logic randy,
	input wire logic [num_channels-1:0] hit_strobe,
	output logic record_strobe,
	output hit_record_t record
);

	// free-running cycle counter
	logic [timestamp_width-1:0] timestamp;

	// true in any cycle with at least one channel hit
	logic any_hit;

	assign any_hit = |hit_strobe;

	// counts every cycle and wraps, no enable
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			timestamp <= '0;
		end else begin
			timestamp <= timestamp + 1'b1;
		end
	end

	// the strobe marks the record for exactly one cycle
	// back to back hit cycles give back to back records
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			record_strobe <= 1'b0;
		end else begin
			record_strobe <= any_hit;
		end
	end

	// record payload
	// stamp is the count in the cycle the hits arrived
	always_ff @(posedge clock) begin
		if (any_hit) begin
			record.timestamp <= timestamp;
			record.hit_mask <= hit_strobe;
		end
	end

endmodule

`default_nettype wire

/* hdl/hit_scaler.sv */
`default_nettype none

module hit_scaler
	import hit_capture_pkg::*;
#(
	parameter int num_channels = num_channels_default,
	parameter int count_width = count_width_default
) (
	input wire logic clock,
	input wire logic randy,
	input wire logic [num_channels-1:0] hit_strobe,
	input wire logic read_strobe,
	input wire logic [channel_index_width(num_channels)-1:0] read_channel,
	output logic read_valid,
	output logic [count_width-1:0] read_data
);

	// one counter per channel
	logic [count_width-1:0] counts [num_channels];

	// selected count, zero for an index past the last channel
	logic [count_width-1:0] selected;

	for (genvar i = 0; i < num_channels; i++) begin : g_counter
		// counter is full at all ones
		logic full;

		assign full = &counts[i];

		// holds at the maximum instead of wrapping
		always_ff @(posedge clock or posedge randy) begin
			if (randy) begin
				counts[i] <= '0;
			end else if (hit_strobe[i] && !full) begin
				counts[i] <= counts[i] + 1'b1;
			end
		end
	end

	always_comb begin
		selected = '0;
		if (read_channel < num_channels) begin
			selected = counts[read_channel];
		end
	end

	// answer one cycle after the request
	always_ff @(posedge clock or posedge randy) begin
		if (randy) begin
			read_valid <= 1'b0;
		end else begin
			read_valid <= read_strobe;
		end
	end

	// a read only copies the count, it never clears it
	always_ff @(posedge clock) begin
		if (read_strobe) begin
			read_data <= selected;
		end
	end

endmodule

`default_nettype wire

/* hdl/hit_capture_top.sv */
`default_nettype none

module hit_capture_top
	import hit_capture_pkg::*;
#(
	parameter int num_channels = num_channels_default,
	parameter int timestamp_width = timestamp_width_default,
	parameter int count_width = count_width_default
) (
	input wire logic clock,
	input wire logic randy,
	input wire logic [num_channels-1:0] hit_in,
	input wire logic read_strobe,
	input wire logic [channel_index_width(num_channels)-1:0] read_channel,
	output logic record_strobe,
	output hit_record_t record,
	output logic read_valid,
	output logic [count_width-1:0] read_data
);

	// synchronized level from each catcher
	logic [num_channels-1:0] sync_level;

	// one cycle hit strobe per channel
	logic [num_channels-1:0] hit_strobe;

	// per channel front end
	// catcher then edge detector, same latency on every channel
	for (genvar ch = 0; ch < num_channels; ch++) begin : g_channel
		pulse_catcher catcher (
			.clock(clock),
			.randy(randy),
			.hit_in(hit_in[ch]),
			.sync_level(sync_level[ch])
		);

		edge_to_pulse #(
			.depth(3)
		) edge_detect (
			.clock(clock),
			.randy(randy),
			.level(sync_level[ch]),
			.pulse(hit_strobe[ch])
		);
	end

	// time-stamped records of hit cycles
	hit_recorder #(
		.num_channels(num_channels),
		.timestamp_width(timestamp_width)
	) recorder (
		.clock(clock),
		.randy(randy),
		.hit_strobe(hit_strobe),
		.record_strobe(record_strobe),
		.record(record)
	);

	// per channel hit counts
	hit_scaler #(
		.num_channels(num_channels),
		.count_width(count_width)
	) scaler (
		.clock(clock),
		.randy(randy),
		.hit_strobe(hit_strobe),
		.read_strobe(read_strobe),
		.read_channel(read_channel),
		.read_valid(read_valid),
		.read_data(read_data)
	);

endmodule

`default_nettype wire

/* tb/hit_capture_props.sv */
`default_nettype none

module hit_capture_props
	import hit_capture_pkg::*;
#(
	parameter int num_channels = num_channels_default
) (
	input wire logic clock,
	input wire logic randy,
	input wire logic [num_channels-1:0] hit_strobe,
	input wire logic record_strobe,
	input wire logic [num_channels-1:0] record_mask,
	input wire logic read_strobe,
	input wire logic read_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	logic any_hit;

	assign any_hit = |hit_strobe;

	// back to back records need hits in both cycles before
	back_to_back_records: assert property (@(posedge clock) disable iff (randy)
		(record_strobe && $past(record_strobe)) |-> ($past(any_hit) && $past(any_hit, 2))
	) else $error("two records in a row without hits in both cycles before them");

	record_mask_set: assert property (@(posedge clock) disable iff (randy)
		record_strobe |-> (record_mask != '0)
	) else $error("record strobe with an empty hit mask");

	// answer exactly one cycle after the request
	read_answered: assert property (@(posedge clock) disable iff (randy)
		read_strobe |=> read_valid
	) else $error("read strobe not answered in the next cycle");

	read_requested: assert property (@(posedge clock) disable iff (randy)
		read_valid |-> $past(read_strobe)
	) else $error("read valid without a read strobe one cycle before");

endmodule

// the recorder has no read port, the scaler no record
bind hit_recorder hit_capture_props #(
	.num_channels(num_channels)
) recorder_props (
	.clock(clock),
	.randy(randy),
	.hit_strobe(hit_strobe),
	.record_strobe(record_strobe),
	.record_mask(record.hit_mask),
	.read_strobe(1'b0),
	.read_valid(1'b0)
);

bind hit_scaler hit_capture_props #(
	.num_channels(num_channels)
) scaler_props (
	.clock(clock),
	.randy(randy),
	.hit_strobe(hit_strobe),
	.record_strobe(1'b0),
	.record_mask('0),
	.read_strobe(read_strobe),
	.read_valid(read_valid)
);

`default_nettype wire

/* tb/hit_capture_tb.sv */
`default_nettype none

module hit_capture_tb
	import hit_capture_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_channels = num_channels_default;
	localparam int index_width = channel_index_width(num_channels);
	localparam int count_max = 255;

	logic clock;
	logic randy;
	logic [num_channels-1:0] hit_in;
	logic read_strobe;
	logic [index_width-1:0] read_channel;
	logic record_strobe;
	hit_record_t record;
	logic read_valid;
	logic [count_width_default-1:0] read_data;

	// hits sent per channel, without saturation
	int hit_total [num_channels];
	int mismatch_errors;
	int timeout_errors;
	int other_errors;
	// falling edges since the current pulse went out
	int elapsed;
	logic awaiting;
	logic have_previous;
	logic [num_channels-1:0] expected_mask;
	logic [timestamp_width_default-1:0] previous_stamp;
	int previous_gap;

	hit_capture_top #(
		.num_channels(num_channels),
		.timestamp_width(timestamp_width_default),
		.count_width(count_width_default)
	) DUT (
		.clock(clock),
		.randy(randy),
		.hit_in(hit_in),
		.read_strobe(read_strobe),
		.read_channel(read_channel),
		.record_strobe(record_strobe),
		.record(record),
		.read_valid(read_valid),
		.read_data(read_data)
	);

	always #4 clock = ~clock;

	// one falling edge, checking any record seen there
	task automatic next_cycle();
		logic [timestamp_width_default-1:0] step;
		@(negedge clock);
		elapsed++;
		if (record_strobe) begin
			assert (awaiting) else begin
				other_errors++;
				$display("unexpected record at %0t with mask %b", $time, record.hit_mask);
			end
			if (awaiting) begin
				step = record.timestamp - previous_stamp;
				assert (record.hit_mask == expected_mask) else begin
					mismatch_errors++;
					$display("mismatch at %0t: mask %b, expected %b", $time,
						record.hit_mask, expected_mask);
				end
				assert (!have_previous || step == previous_gap[timestamp_width_default-1:0])
				else begin
					mismatch_errors++;
					$display("mismatch at %0t: stamp step %0d, expected %0d", $time, step,
						previous_gap);
				end
				previous_stamp = record.timestamp;
				have_previous = 1'b1;
				awaiting = 1'b0;
			end
		end
	endtask

	task automatic read_count(input int channel, output int value);
		int tries;
		read_strobe = 1'b1;
		read_channel = index_width'(channel);
		next_cycle();
		read_strobe = 1'b0;
		tries = 0;
		while (!read_valid && tries < 4) begin
			next_cycle();
			tries++;
		end
		assert (read_valid) else begin
			timeout_errors++;
			$display("scaler gave no answer for channel %0d", channel);
		end
		value = int'(read_data);
	endtask

	// two reads in a row, both against the trace count
	task automatic check_channel(input int channel);
		int first;
		int second;
		int expected;
		expected = (hit_total[channel] > count_max) ? count_max : hit_total[channel];
		read_count(channel, first);
		read_count(channel, second);
		assert (first == expected) else begin
			mismatch_errors++;
			$display("mismatch at %0t: channel %0d count %0d, expected %0d", $time, channel,
				first, expected);
		end
		assert (second == first) else begin
			mismatch_errors++;
			$display("mismatch at %0t: channel %0d reread %0d after %0d", $time, channel,
				second, first);
		end
	endtask

	task automatic run_event(input logic [num_channels-1:0] mask, input int width,
		input int gap);
		int tries;
		elapsed = 0;
		hit_in = mask;
		expected_mask = mask;
		awaiting = 1'b1;
		for (int ch = 0; ch < num_channels; ch++) begin
			if (mask[ch]) begin
				hit_total[ch]++;
			end
		end
		// width is in tenths of a ns
		fork
			begin
				#(width / 10.0);
				hit_in = '0;
			end
		join_none
		tries = 0;
		while (awaiting && tries < 12) begin
			next_cycle();
			tries++;
		end
		assert (!awaiting) else begin
			timeout_errors++;
			$display("no record arrived for mask %b", mask);
			awaiting = 1'b0;
		end
		if (gap - elapsed >= 3) begin
			check_channel($urandom_range(num_channels - 1));
		end
		assert (elapsed <= gap) else begin
			other_errors++;
			$display("event with mask %b took longer than its gap of %0d", mask, gap);
		end
		while (elapsed < gap) begin
			next_cycle();
		end
		previous_gap = gap;
	endtask

	initial begin
		int fd;
		int mask;
		int width;
		int gap;
		int repeats;
		string line;
		void'($urandom(32'h22ec));
		clock = 1'b0;
		randy = 1'b1;
		hit_in = '0;
		read_strobe = 1'b0;
		read_channel = '0;
		mismatch_errors = 0;
		timeout_errors = 0;
		other_errors = 0;
		elapsed = 0;
		awaiting = 1'b0;
		have_previous = 1'b0;
		expected_mask = '0;
		previous_stamp = '0;
		previous_gap = 0;
		for (int ch = 0; ch < num_channels; ch++) begin
			hit_total[ch] = 0;
		end
		// three rising edges under reset
		for (int i = 0; i < 3; i++) begin
			next_cycle();
		end
		randy = 1'b0;
		for (int i = 0; i < 5; i++) begin
			next_cycle();
		end
		fd = $fopen("tb/hit_trace.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open the trace file tb/hit_trace.txt");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if ($sscanf(line, "%h %d %d %d", mask, width, gap, repeats) == 4) begin
					for (int n = 0; n < repeats; n++) begin
						run_event(mask[num_channels-1:0], width, gap);
					end
				end
			end
			$fclose(fd);
		end
		// quiet stretch, then every channel once more
		for (int i = 0; i < 20; i++) begin
			next_cycle();
		end
		for (int ch = 0; ch < num_channels; ch++) begin
			check_channel(ch);
		end
		$display("errors: %0d mismatch, %0d timeout, %0d other", mismatch_errors,
			timeout_errors, other_errors);
		if (mismatch_errors + timeout_errors + other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/hit_trace.txt */
# mask (hex), pulse width (tenths of a ns), gap to next event (cycles), repeat count
# each repeat is one event and one record, widths below 80 are under one clock period
1 30 12 1
2 5 10 1
4 75 9 1
8 115 16 1
3 38 8 1
c 15 11 1
f 60 20 1
5 195 14 1
a 8 8 2
1 25 8 3
6 90 13 1
9 45 10 4
f 12 8 2
2 55 8 40
4 35 9 30
1 22 8 270
8 65 12 5
7 150 16 1
f 30 24 1

/* sources.f */
hdl/hit_capture_pkg.sv
hdl/pulse_catcher.sv
hdl/edge_to_pulse.sv
hdl/hit_recorder.sv
hdl/hit_scaler.sv
hdl/hit_capture_top.sv
tb/hit_capture_props.sv
tb/hit_capture_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the hit capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module hit_capture_tb -f sources.f

./obj_dir/Vhit_capture_tb | tee sim.log

grep -q "Result: PASSED" sim.log
